/* filelist.f */
+incdir+source
source/rv_pkg.sv
source/pipe_reg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_unit.sv
source/rv_core.sv
test/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_rv_core -Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_rv_core)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF '** PASS **' <<< "$sim_out"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* source/decode_stage.sv */
`default_nettype none

`include "rv_settings.svh"

module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::if_id_t   if_id,
    input  logic             stall,
    input  logic             flush,
    input  rv_pkg::retire_t  wb,
    input  logic             wb_valid,
    output rv_pkg::reg_idx_t rs1_d,
    output rv_pkg::reg_idx_t rs2_d,
    output rv_pkg::id_ex_t   id_ex
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    logic       use_rs1;
    logic       use_rs2;
    id_ex_t     dec;
    id_ex_t     id_ex_d;
    logic       wb_we;

    // x0 has no storage
    word_t      regs [1:`RV_REG_COUNT-1];
    reg_idx_t   rd_idx [2];
    word_t      rd_val [2];

    // Instruction fields
    assign opcode = if_id.instr[6:0];
    assign funct3 = if_id.instr[14:12];
    assign funct7 = if_id.instr[31:25];

    // Sign extended immediates
    assign imm_i = {{(`RV_XLEN-12){if_id.instr[31]}}, if_id.instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
    assign imm_b = {{(`RV_XLEN-13){if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                    if_id.instr[30:25], if_id.instr[11:8], 1'b0};

    // Control decode
    // Anything outside the subset keeps all control bits low
    always_comb begin
        dec       = '0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        dec.valid = if_id.valid;
        dec.pc    = if_id.pc;
        if (if_id.valid) begin
            case (opcode)
                `RV_OP_RTYPE: begin
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    if (funct7 == 7'b0000000 && funct3 == 3'b000) begin
                        dec.alu_op    = ALU_ADD;
                        dec.reg_write = 1'b1;
                    end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                        dec.alu_op    = ALU_SUB;
                        dec.reg_write = 1'b1;
                    end else if (funct7 == 7'b0000000 && funct3 == 3'b111) begin
                        dec.alu_op    = ALU_AND;
                        dec.reg_write = 1'b1;
                    end else if (funct7 == 7'b0000000 && funct3 == 3'b110) begin
                        dec.alu_op    = ALU_OR;
                        dec.reg_write = 1'b1;
                    end
                end
                `RV_OP_ITYPE: begin
                    // ADDI only
                    if (funct3 == 3'b000) begin
                        use_rs1       = 1'b1;
                        dec.imm       = imm_i;
                        dec.use_imm   = 1'b1;
                        dec.reg_write = 1'b1;
                    end
                end
                `RV_OP_LOAD: begin
                    // LW only, address is rs1 plus offset
                    if (funct3 == 3'b010) begin
                        use_rs1       = 1'b1;
                        dec.imm       = imm_i;
                        dec.use_imm   = 1'b1;
                        dec.reg_write = 1'b1;
                        dec.mem_read  = 1'b1;
                    end
                end
                `RV_OP_STORE: begin
                    if (funct3 == 3'b010) begin
                        use_rs1       = 1'b1;
                        use_rs2       = 1'b1;
                        dec.imm       = imm_s;
                        dec.use_imm   = 1'b1;
                        dec.mem_write = 1'b1;
                    end
                end
                `RV_OP_BRANCH: begin
                    // BEQ only, compare happens in execute
                    if (funct3 == 3'b000) begin
                        use_rs1       = 1'b1;
                        use_rs2       = 1'b1;
                        dec.imm       = imm_b;
                        dec.is_branch = 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
        // Unused index fields read as x0 so they never match in the hazard unit
        dec.rs1 = use_rs1 ? if_id.instr[19:15] : '0;
        dec.rs2 = use_rs2 ? if_id.instr[24:20] : '0;
        dec.rd  = dec.reg_write ? if_id.instr[11:7] : '0;
    end

    assign rs1_d     = dec.rs1;
    assign rs2_d     = dec.rs2;
    assign rd_idx[0] = dec.rs1;
    assign rd_idx[1] = dec.rs2;

    // Register file write port
    assign wb_we = wb_valid && wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Read ports
    // Same-cycle write shows through
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (rd_idx[p] == '0) begin
                rd_val[p] = '0;
            end else if (wb_we && (wb.rd == rd_idx[p])) begin
                rd_val[p] = wb.data;
            end else begin
                rd_val[p] = regs[rd_idx[p]];
            end
        end
    end

    always_comb begin
        id_ex_d         = dec;
        id_ex_d.rs1_val = rd_val[0];
        id_ex_d.rs2_val = rd_val[1];
    end

    // ID/EX boundary
    // Stall inserts a bubble here while IF/ID holds
    pipe_reg #(
        .payload_t(id_ex_t)
    ) i_id_ex_reg (
        .clk  (clk),
        .rst_n(rst_n),
        .hold (1'b0),
        .flush(stall || flush),
        .d    (id_ex_d),
        .q    (id_ex)
    );

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::fwd_sel_e  fwd_a,
    input  rv_pkg::fwd_sel_e  fwd_b,
    input  rv_pkg::word_t     mem_result,
    input  rv_pkg::word_t     wb_result,
    output rv_pkg::redirect_t redirect,
    output rv_pkg::ex_mem_t   ex_mem
);
    import rv_pkg::*;

    word_t   op_a;
    word_t   rs2_fwd;
    word_t   op_b;
    word_t   alu_result;
    ex_mem_t ex_mem_d;

    // Operand A
    always_comb begin
        case (fwd_a)
            FWD_FROM_MEM: op_a = mem_result;
            FWD_FROM_WB:  op_a = wb_result;
            default:      op_a = id_ex.rs1_val;
        endcase
    end

    // Forwarded rs2 serves the ALU, the store data and the branch compare
    always_comb begin
        case (fwd_b)
            FWD_FROM_MEM: rs2_fwd = mem_result;
            FWD_FROM_WB:  rs2_fwd = wb_result;
            default:      rs2_fwd = id_ex.rs2_val;
        endcase
    end

    assign op_b = id_ex.use_imm ? id_ex.imm : rs2_fwd;

    // ALU
    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            default: alu_result = op_a + op_b;
        endcase
    end

    // BEQ resolves here
    // Target is pc relative
    assign redirect.taken  = id_ex.valid && id_ex.is_branch && (op_a == rs2_fwd);
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_comb begin
        ex_mem_d.valid      = id_ex.valid;
        ex_mem_d.pc         = id_ex.pc;
        ex_mem_d.rd         = id_ex.rd;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = rs2_fwd;
        ex_mem_d.reg_write  = id_ex.reg_write;
        ex_mem_d.mem_read   = id_ex.mem_read;
        ex_mem_d.mem_write  = id_ex.mem_write;
    end

    // EX/MEM boundary
    pipe_reg #(
        .payload_t(ex_mem_t)
    ) i_ex_mem_reg (
        .clk  (clk),
        .rst_n(rst_n),
        .hold (1'b0),
        .flush(1'b0),
        .d    (ex_mem_d),
        .q    (ex_mem)
    );

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
`default_nettype none

`include "rv_settings.svh"

module fetch_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  rv_pkg::redirect_t redirect,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::if_id_t    if_id
);
    import rv_pkg::*;

    word_t  pc;
    if_id_t if_id_d;

    // Program counter
    // Redirect first, then stall, else sequential
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else if (!stall) begin
            pc <= pc + word_t'(4);
        end
    end

    // Instruction memory answers in the same cycle
    assign imem_addr = pc;

    always_comb begin
        if_id_d.valid = 1'b1;
        if_id_d.pc    = pc;
        if_id_d.instr = imem_data;
    end

    // IF/ID boundary
    pipe_reg #(
        .payload_t(if_id_t)
    ) i_if_id_reg (
        .clk  (clk),
        .rst_n(rst_n),
        .hold (stall),
        .flush(redirect.taken),
        .d    (if_id_d),
        .q    (if_id)
    );

endmodule

`default_nettype wire

/* source/hazard_unit.sv */
`default_nettype none

module hazard_unit (
    input  rv_pkg::reg_idx_t rs1_e,
    input  rv_pkg::reg_idx_t rs2_e,
    input  rv_pkg::reg_idx_t rs1_d,
    input  rv_pkg::reg_idx_t rs2_d,
    input  rv_pkg::reg_idx_t rd_e,
    input  rv_pkg::reg_idx_t rd_m,
    input  rv_pkg::reg_idx_t rd_w,
    input  logic             reg_write_m,
    input  logic             reg_write_w,
    input  logic             mem_read_e,
    output rv_pkg::fwd_sel_e fwd_a,
    output rv_pkg::fwd_sel_e fwd_b,
    output logic             stall
);
    import rv_pkg::*;

    // Youngest producer wins
    // x0 is never a forwarding source
    function automatic fwd_sel_e pick_fwd(
        input reg_idx_t rs,
        input reg_idx_t rd_mem,
        input logic     we_mem,
        input reg_idx_t rd_wb,
        input logic     we_wb
    );
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (we_mem && (rd_mem != '0) && (rd_mem == rs)) begin
            sel = FWD_FROM_MEM;
        end else if (we_wb && (rd_wb != '0) && (rd_wb == rs)) begin
            sel = FWD_FROM_WB;
        end
        return sel;
    endfunction

    assign fwd_a = pick_fwd(rs1_e, rd_m, reg_write_m, rd_w, reg_write_w);
    assign fwd_b = pick_fwd(rs2_e, rd_m, reg_write_m, rd_w, reg_write_w);

    // Load in execute feeding decode
    // One cycle of stall lets the load reach writeback
    assign stall = mem_read_e && (rd_e != '0) && ((rd_e == rs1_d) || (rd_e == rs2_d));

endmodule

`default_nettype wire

/* source/memory_stage.sv */
`default_nettype none

module memory_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::ex_mem_t   ex_mem,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::mem_wb_t   mem_wb
);
    import rv_pkg::*;

    mem_wb_t mem_wb_d;

    // Data memory request
    // Strobes only for a live entry
    always_comb begin
        dmem_req.addr  = ex_mem.alu_result;
        dmem_req.wdata = ex_mem.store_data;
        dmem_req.read  = ex_mem.valid && ex_mem.mem_read;
        dmem_req.write = ex_mem.valid && ex_mem.mem_write;
    end

    // Load data arrives in the same cycle
    always_comb begin
        mem_wb_d.valid     = ex_mem.valid;
        mem_wb_d.pc        = ex_mem.pc;
        mem_wb_d.rd        = ex_mem.rd;
        mem_wb_d.result    = ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;
        mem_wb_d.reg_write = ex_mem.reg_write;
    end

    // MEM/WB boundary
    pipe_reg #(
        .payload_t(mem_wb_t)
    ) i_mem_wb_reg (
        .clk  (clk),
        .rst_n(rst_n),
        .hold (1'b0),
        .flush(1'b0),
        .d    (mem_wb_d),
        .q    (mem_wb)
    );

endmodule

`default_nettype wire

/* source/pipe_reg.sv */
`default_nettype none

// One pipeline boundary
// Bubble is the all-zero payload so valid and every control bit drop together
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            // Flush beats hold so a redirect wins over a stall
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
        // Hold keeps the current entry
    end

endmodule

`default_nettype wire

/* source/rv_core.sv */
`default_nettype none

module rv_core (
    input  logic              clk,
    input  logic              rst_n,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::word_t     dmem_rdata,
    output logic              retire_valid,
    output rv_pkg::retire_t   retire
);
    import rv_pkg::*;

    logic      stall;
    redirect_t redirect;
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    reg_idx_t  rs1_d;
    reg_idx_t  rs2_d;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    retire_t   wb;

    fetch_stage i_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .redirect (redirect),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .if_id    (if_id)
    );

    // Taken branch also kills the instruction in decode
    decode_stage i_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .if_id   (if_id),
        .stall   (stall),
        .flush   (redirect.taken),
        .wb      (wb),
        .wb_valid(mem_wb.valid),
        .rs1_d   (rs1_d),
        .rs2_d   (rs2_d),
        .id_ex   (id_ex)
    );

    // Memory-stage forward is the ALU result
    execute_stage i_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_ex     (id_ex),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .mem_result(ex_mem.alu_result),
        .wb_result (mem_wb.result),
        .redirect  (redirect),
        .ex_mem    (ex_mem)
    );

    memory_stage i_memory (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_mem    (ex_mem),
        .dmem_req  (dmem_req),
        .dmem_rdata(dmem_rdata),
        .mem_wb    (mem_wb)
    );

    hazard_unit i_hazard (
        .rs1_e      (id_ex.rs1),
        .rs2_e      (id_ex.rs2),
        .rs1_d      (rs1_d),
        .rs2_d      (rs2_d),
        .rd_e       (id_ex.rd),
        .rd_m       (ex_mem.rd),
        .rd_w       (mem_wb.rd),
        .reg_write_m(ex_mem.valid && ex_mem.reg_write),
        .reg_write_w(mem_wb.valid && mem_wb.reg_write),
        .mem_read_e (id_ex.valid && id_ex.mem_read),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .stall      (stall)
    );

    // Writeback record
    // Same record feeds the register file and the retire port
    always_comb begin
        wb.pc        = mem_wb.pc;
        wb.rd        = mem_wb.rd;
        wb.data      = mem_wb.result;
        wb.reg_write = mem_wb.reg_write;
    end

    assign retire_valid = mem_wb.valid;
    assign retire       = wb;

endmodule

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

    // Register index wide enough for the whole register file
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

    typedef logic [`RV_XLEN-1:0] word_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE     = 2'b00,
        FWD_FROM_WB  = 2'b01,
        FWD_FROM_MEM = 2'b10
    } fwd_sel_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    // Decoded instruction with operand values read in decode
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     is_branch;
    } id_ex_t;

    // Pc rides along so writeback can report it
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    store_data;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    result;
        logic     reg_write;
    } mem_wb_t;

    // Writeback record as seen by decode and at the core ports
    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    data;
        logic     reg_write;
    } retire_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } dmem_req_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

/* source/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and address width
`define RV_XLEN 32

// Architectural registers including x0
`define RV_REG_COUNT 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Major opcodes of the supported subset
`define RV_OP_RTYPE 7'b0110011
`define RV_OP_ITYPE 7'b0010011
`define RV_OP_LOAD 7'b0000011
`define RV_OP_STORE 7'b0100011
`define RV_OP_BRANCH 7'b1100011

`endif

/* test/tb_rv_core.sv */
`default_nettype none

`include "rv_settings.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_pkg::*;

    logic      clk;
    logic      rst_n;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    logic      retire_valid;
    retire_t   retire;

    // Memory models of 64 words each
    word_t     imem [64];
    word_t     dmem [64];

    // Reference interpreter state
    word_t     ref_mem [64];
    word_t     ref_regs [32];

    word_t     prog [$];
    retire_t   exp_retire [$];
    dmem_req_t exp_store [$];

    logic [31:0] lfsr;
    int          error_count;
    int          retire_checks;
    int          store_checks;

    rv_core i_rv_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .dmem_req    (dmem_req),
        .dmem_rdata  (dmem_rdata),
        .retire_valid(retire_valid),
        .retire      (retire)
    );

    always #5 clk = ~clk;

    // Both memories answer in the same cycle
    // Fetch past the ROM reads an all-zero word that decodes as a no-op
    assign imem_data  = (imem_addr < 32'd256) ? imem[imem_addr[7:2]] : '0;
    // Load data only shows up under the read strobe
    assign dmem_rdata = dmem_req.read ? dmem[dmem_req.addr[7:2]] : '0;

    // RAM write lands mid-cycle while the request is stable
    always @(negedge clk) begin
        if (rst_n && dmem_req.write) begin
            dmem[dmem_req.addr[7:2]] = dmem_req.wdata;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'hd000_0001 : 32'h0);
        end
        return v;
    endfunction

    // Instruction encoders
    function automatic word_t enc_r(input int f7, input int f3, input int rd,
                                    input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OP_RTYPE};
    endfunction

    function automatic word_t enc_add(input int rd, input int rs1, input int rs2);
        return enc_r(0, 0, rd, rs1, rs2);
    endfunction

    function automatic word_t enc_sub(input int rd, input int rs1, input int rs2);
        return enc_r(32, 0, rd, rs1, rs2);
    endfunction

    function automatic word_t enc_and(input int rd, input int rs1, input int rs2);
        return enc_r(0, 7, rd, rs1, rs2);
    endfunction

    function automatic word_t enc_or(input int rd, input int rs1, input int rs2);
        return enc_r(0, 6, rd, rs1, rs2);
    endfunction

    function automatic word_t enc_i(input logic [6:0] op, input int f3, input int rd,
                                    input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_addi(input int rd, input int rs1, input int imm);
        return enc_i(`RV_OP_ITYPE, 0, rd, rs1, imm);
    endfunction

    function automatic word_t enc_lw(input int rd, input int rs1, input int imm);
        return enc_i(`RV_OP_LOAD, 2, rd, rs1, imm);
    endfunction

    function automatic word_t enc_sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    // Offset is relative to the branch itself
    function automatic word_t enc_beq(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
                `RV_OP_BRANCH};
    endfunction

    // ISA-level interpreter over the loaded ROM
    // Fills the ordered retire and store lists
    task automatic interpret(input int len);
        word_t     instr;
        word_t     pc;
        word_t     next_pc;
        word_t     a;
        word_t     b;
        word_t     addr;
        word_t     res;
        logic      wr;
        int        steps;
        retire_t   r;
        dmem_req_t s;
        pc = `RV_RESET_PC;
        steps = 0;
        while ((pc < word_t'(len * 4)) && (steps < len * 4)) begin
            instr   = imem[pc[7:2]];
            a       = ref_regs[instr[19:15]];
            b       = ref_regs[instr[24:20]];
            res     = '0;
            wr      = 1'b0;
            next_pc = pc + 32'd4;
            case (instr[6:0])
                `RV_OP_RTYPE: begin
                    wr = 1'b1;
                    case ({instr[31:25], instr[14:12]})
                        {7'h00, 3'h0}: res = a + b;
                        {7'h20, 3'h0}: res = a - b;
                        {7'h00, 3'h7}: res = a & b;
                        {7'h00, 3'h6}: res = a | b;
                        default: wr = 1'b0;
                    endcase
                end
                `RV_OP_ITYPE: begin
                    if (instr[14:12] == 3'h0) begin
                        res = a + {{20{instr[31]}}, instr[31:20]};
                        wr  = 1'b1;
                    end
                end
                `RV_OP_LOAD: begin
                    if (instr[14:12] == 3'h2) begin
                        addr = a + {{20{instr[31]}}, instr[31:20]};
                        res  = ref_mem[addr[7:2]];
                        wr   = 1'b1;
                    end
                end
                `RV_OP_STORE: begin
                    if (instr[14:12] == 3'h2) begin
                        addr    = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                        ref_mem[addr[7:2]] = b;
                        s.addr  = addr;
                        s.wdata = b;
                        s.read  = 1'b0;
                        s.write = 1'b1;
                        exp_store.push_back(s);
                    end
                end
                `RV_OP_BRANCH: begin
                    // BEQ only
                    if ((instr[14:12] == 3'h0) && (a == b)) begin
                        next_pc = pc + {{19{instr[31]}}, instr[31], instr[7],
                                        instr[30:25], instr[11:8], 1'b0};
                    end
                end
                default: begin
                end
            endcase
            r.pc        = pc;
            r.reg_write = wr;
            r.rd        = wr ? instr[11:7] : '0;
            r.data      = res;
            exp_retire.push_back(r);
            // x0 stays zero
            if (wr && (instr[11:7] != 5'd0)) begin
                ref_regs[instr[11:7]] = res;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    // Rd and data only matter for a register write
    task automatic check_retire(input retire_t got, input retire_t exp);
        retire_checks++;
        if ((got.pc !== exp.pc) || (got.reg_write !== exp.reg_write) ||
            (exp.reg_write && ((got.rd !== exp.rd) || (got.data !== exp.data)))) begin
            error_count++;
            $display("[FAIL] retire got pc=%h rd=%h data=%h reg_write=%h",
                     got.pc, got.rd, got.data, got.reg_write);
            $display("[FAIL] retire expected pc=%h rd=%h data=%h reg_write=%h",
                     exp.pc, exp.rd, exp.data, exp.reg_write);
        end
    endtask

    task automatic check_store(input dmem_req_t got, input dmem_req_t exp);
        store_checks++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] dmem_req got addr=%h wdata=%h read=%h write=%h",
                     got.addr, got.wdata, got.read, got.write);
            $display("[FAIL] dmem_req expected addr=%h wdata=%h read=%h write=%h",
                     exp.addr, exp.wdata, exp.read, exp.write);
        end
    endtask

    // Called mid-cycle
    // Retires outside the program are the filler past its end
    task automatic sample_outputs(input int len);
        retire_t   exp_r;
        dmem_req_t exp_s;
        if (retire_valid && (retire.pc < word_t'(len * 4))) begin
            if (exp_retire.size() == 0) begin
                error_count++;
                $display("Unexpected extra retire of the instruction at pc %h", retire.pc);
            end else begin
                exp_r = exp_retire.pop_front();
                check_retire(retire, exp_r);
            end
        end
        if (dmem_req.write) begin
            if (exp_store.size() == 0) begin
                error_count++;
                $display("Unexpected store to address %h", dmem_req.addr);
            end else begin
                exp_s = exp_store.pop_front();
                check_store(dmem_req, exp_s);
            end
        end
    endtask

    // Loads prog under reset, runs the interpreter, then checks the core
    task automatic run_program(input string name);
        int len;
        int limit;
        int cycles;
        len   = prog.size();
        limit = len * 3 + 50;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        foreach (prog[i]) begin
            imem[i] = prog[i];
        end
        ref_mem = dmem;
        exp_retire.delete();
        exp_store.delete();
        interpret(len);
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (retire_valid || dmem_req.read || dmem_req.write) begin
            error_count++;
            $display("Core outputs are not idle during reset in %s", name);
        end
        @(posedge clk);
        #1;
        rst_n  = 1'b1;
        cycles = 0;
        while (((exp_retire.size() != 0) || (exp_store.size() != 0)) && (cycles < limit)) begin
            @(negedge clk);
            sample_outputs(len);
            cycles++;
        end
        if ((exp_retire.size() != 0) || (exp_store.size() != 0)) begin
            error_count++;
            $display("Timeout in %s: %0d retires and %0d stores missing after %0d cycles",
                     name, exp_retire.size(), exp_store.size(), cycles);
            $display("Checks: %0d retires, %0d stores, %0d errors",
                     retire_checks, store_checks, error_count);
            $display("** FAIL **");
            $finish;
        end else begin
            // Catch late duplicates and flushed instructions
            repeat (8) begin
                @(negedge clk);
                sample_outputs(len);
            end
            $display("%s finished in %0d cycles", name, cycles);
        end
    endtask

    // Behavior 1 with random immediates
    task automatic test_alu_independent();
        int imm [4];
        for (int i = 0; i < 4; i++) begin
            imm[i] = rand_bits(12);
        end
        prog.delete();
        prog.push_back(enc_addi(1, 0, imm[0]));
        prog.push_back(enc_addi(2, 0, imm[1]));
        prog.push_back(enc_addi(3, 0, imm[2]));
        prog.push_back(enc_addi(4, 0, imm[3]));
        prog.push_back(enc_add(5, 1, 2));
        prog.push_back(enc_sub(6, 3, 4));
        prog.push_back(enc_and(7, 1, 3));
        prog.push_back(enc_or(8, 2, 4));
        run_program("alu_independent");
    endtask

    // Behavior 2 with producers one and two slots ahead
    task automatic test_forwarding();
        prog.delete();
        prog.push_back(enc_addi(1, 0, 5));
        prog.push_back(enc_addi(2, 1, 3));
        prog.push_back(enc_add(3, 1, 2));
        prog.push_back(enc_sub(4, 3, 1));
        prog.push_back(enc_or(5, 4, 3));
        prog.push_back(enc_and(6, 5, 5));
        prog.push_back(enc_addi(7, 6, -1));
        prog.push_back(enc_add(7, 7, 7));
        run_program("forwarding");
    endtask

    // Behavior 3 loading from the fill pattern
    task automatic test_load_use();
        prog.delete();
        prog.push_back(enc_addi(1, 0, 32'h20));
        prog.push_back(enc_lw(2, 1, 0));
        prog.push_back(enc_add(3, 2, 2));
        prog.push_back(enc_lw(4, 1, 4));
        prog.push_back(enc_addi(5, 4, 1));
        prog.push_back(enc_lw(6, 1, 8));
        prog.push_back(enc_addi(7, 0, 1));
        prog.push_back(enc_or(8, 6, 7));
        run_program("load_use");
    endtask

    // Behavior 4 where store data also comes through forwarding
    task automatic test_store_load();
        prog.delete();
        prog.push_back(enc_addi(1, 0, 32'h40));
        prog.push_back(enc_addi(2, 0, 32'h123));
        prog.push_back(enc_sw(2, 1, 0));
        prog.push_back(enc_lw(3, 1, 0));
        prog.push_back(enc_addi(4, 3, 7));
        prog.push_back(enc_sw(4, 1, 4));
        prog.push_back(enc_lw(5, 1, 4));
        run_program("store_load");
    endtask

    // Behavior 5 where slots 3, 4 and 10 must never retire
    task automatic test_branches();
        prog.delete();
        prog.push_back(enc_addi(1, 0, 7));
        prog.push_back(enc_addi(2, 0, 7));
        prog.push_back(enc_beq(1, 2, 12));
        prog.push_back(enc_addi(3, 0, 1));
        prog.push_back(enc_addi(4, 0, 2));
        prog.push_back(enc_addi(5, 0, 3));
        prog.push_back(enc_beq(1, 5, 8));
        prog.push_back(enc_addi(6, 0, 4));
        prog.push_back(enc_addi(7, 0, 5));
        prog.push_back(enc_beq(0, 0, 8));
        prog.push_back(enc_addi(9, 0, 9));
        prog.push_back(enc_addi(8, 0, 6));
        run_program("branches");
    endtask

    // Behavior 6 with x0 written right before it is read
    task automatic test_x0();
        prog.delete();
        prog.push_back(enc_addi(0, 0, 32'h55));
        prog.push_back(enc_add(1, 0, 0));
        prog.push_back(enc_addi(0, 1, 32'h7f));
        prog.push_back(enc_addi(2, 0, 1));
        prog.push_back(enc_or(3, 0, 2));
        prog.push_back(enc_add(4, 0, 0));
        run_program("x0_writes");
    endtask

    initial begin
        word_t fill_addr;
        clk           = 1'b0;
        rst_n         = 1'b0;
        lfsr          = 32'h3ad8_a419;
        error_count   = 0;
        retire_checks = 0;
        store_checks  = 0;
        for (int i = 0; i < 64; i++) begin
            fill_addr = word_t'(i * 4);
            imem[i]   = '0;
            dmem[i]   = {~fill_addr[15:0], fill_addr[15:0]};
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        test_alu_independent();
        test_forwarding();
        test_load_use();
        test_store_load();
        test_branches();
        test_x0();
        $display("Checks: %0d retires, %0d stores, %0d errors",
                 retire_checks, store_checks, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
